// ==== common/rdma_wr_config.svh ====
// ********************
// Build-time sizes for the RDMA write credit gate
// Included by the package and every RTL file
// ********************

`ifndef RDMA_WR_CONFIG_SVH
`define RDMA_WR_CONFIG_SVH

`define N_DESTS     2     // Remote destinations
`define DEST_W      1     // Destination index bits
`define QDEPTH      4     // Request queue entries per destination
`define DQ_DEPTH    16    // Data queue beats per destination
`define DATA_W      64    // Beat width
`define BEAT_BYTES  8     // Bytes per full beat
`define ADDR_W      32    // Virtual address
`define LEN_W       16    // Byte length
`define PMTU_BYTES  32    // Path MTU, 4 beats

`endif

// ==== common/rdma_wr_pkg.sv ====
// ********************
// Shared types for the RDMA write credit gate
// Imported in the header of each RTL module
// ********************

`include "rdma_wr_config.svh"

package rdma_wr_pkg;

  // Packet position inside one write request
  typedef enum logic [1:0] {
    OP_ONLY   = 2'd0,  // Whole request fits one MTU
    OP_FIRST  = 2'd1,
    OP_MIDDLE = 2'd2,
    OP_LAST   = 2'd3
  } wr_opcode_t;

  // Output arbiter phases
  typedef enum logic {
    ARB_IDLE = 1'b0,  // Offering a header
    ARB_DATA = 1'b1   // Streaming granted beats
  } arb_state_t;

  // Beats per packet, up to PMTU/8 inclusive
  typedef logic [$clog2(`PMTU_BYTES / `BEAT_BYTES + 1)-1:0] beats_t;

  // Arrived but unreleased beats, bounded by data queue depth
  typedef logic [$clog2(`DQ_DEPTH + 1)-1:0] credit_t;

  typedef logic [`DEST_W-1:0] dest_t;
  typedef logic [`ADDR_W-1:0] vaddr_t;
  typedef logic [`LEN_W-1:0]  len_t;
  typedef logic [`DATA_W-1:0] data_t;

endpackage

// ==== hw/sync_fifo.sv ====
// ********************
// Generic synchronous valid/ready FIFO
// Used as request queue and as data queue
// ********************

`timescale 1ns/1ns

`include "rdma_wr_config.svh"

module sync_fifo #(
  parameter int WIDTH = `DATA_W,
  parameter int DEPTH = `QDEPTH
) (
  input  logic             aclk,
  input  logic             rst_n,
  input  logic             s_valid,
  output logic             s_ready,
  input  logic [WIDTH-1:0] s_data,
  output logic             m_valid,
  input  logic             m_ready,
  output logic [WIDTH-1:0] m_data
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];  // Storage, no reset
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             push;
  logic             pop;

  assign m_valid = (count != '0);
  // Full queue still takes a write when the head leaves this cycle
  assign s_ready = (count != CW'(DEPTH)) || m_ready;
  assign m_data  = mem[rd_ptr];  // Head entry, registered storage

  assign push = s_valid && s_ready;
  assign pop  = m_valid && m_ready;

  always_ff @(posedge aclk) begin
    if (push) mem[wr_ptr] <= s_data;
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
      if (pop)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

// ==== hw/credits/wr_req_parser.sv ====
// ********************
// Splits one write request into path-MTU packets
// One packet per cycle, next request taken on LAST or ONLY
// ********************

`timescale 1ns/1ns

`include "rdma_wr_config.svh"

module wr_req_parser import rdma_wr_pkg::*; (
  input  logic       aclk,
  input  logic       rst_n,
  // Queued request
  input  logic       s_valid,
  output logic       s_ready,
  input  vaddr_t     s_vaddr,
  input  len_t       s_len,
  // Packet towards the credit gate
  output logic       m_valid,
  input  logic       m_ready,
  output wr_opcode_t m_opcode,
  output vaddr_t     m_vaddr,
  output len_t       m_len,
  output beats_t     m_beats
);

  localparam len_t   PMTU_LEN  = len_t'(`PMTU_BYTES);
  localparam vaddr_t PMTU_STEP = vaddr_t'(`PMTU_BYTES);
  localparam int     BEAT_SH   = $clog2(`BEAT_BYTES);

  logic   busy;      // A request is being cut
  logic   first;     // Next packet opens the request
  vaddr_t cur_addr;  // Address of next packet
  len_t   rem;       // Bytes not yet emitted
  logic   is_last;
  logic   pkt_xfer;
  logic   req_xfer;

  // Remainder fits in one packet
  assign is_last = (rem <= PMTU_LEN);

  assign m_valid = busy;
  assign m_vaddr = cur_addr;
  assign m_len   = is_last ? rem : PMTU_LEN;
  assign m_beats = beats_t'(m_len >> BEAT_SH);  // Lengths are whole beats

  always_comb begin
    if (first) m_opcode = is_last ? OP_ONLY : OP_FIRST;
    else       m_opcode = is_last ? OP_LAST : OP_MIDDLE;
  end

  assign pkt_xfer = m_valid && m_ready;
  // Idle, or closing the current request this cycle
  assign s_ready  = !busy || (m_ready && is_last);
  assign req_xfer = s_valid && s_ready;

  // Control
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      first <= 1'b0;
    end else if (req_xfer) begin
      busy  <= 1'b1;
      first <= 1'b1;
    end else if (pkt_xfer) begin
      first <= 1'b0;
      if (is_last) busy <= 1'b0;  // Nothing left to cut
    end
  end

  // Address and remaining bytes
  always_ff @(posedge aclk) begin
    if (req_xfer) begin
      cur_addr <= s_vaddr;
      rem      <= s_len;
    end else if (pkt_xfer) begin
      cur_addr <= cur_addr + PMTU_STEP;
      rem      <= rem - PMTU_LEN;  // Unused once last packet left
    end
  end

endmodule

// ==== hw/credits/wr_credit_gate.sv ====
// ********************
// Holds each packet until its data beats have arrived
// Registered packet output towards the arbiter
// ********************

`timescale 1ns/1ns

`include "rdma_wr_config.svh"

module wr_credit_gate import rdma_wr_pkg::*; (
  input  logic       aclk,
  input  logic       rst_n,
  input  logic       xfer,      // One beat written into the data queue
  // Packet from the parser
  input  logic       s_valid,
  output logic       s_ready,
  input  wr_opcode_t s_opcode,
  input  vaddr_t     s_vaddr,
  input  len_t       s_len,
  input  beats_t     s_beats,
  // Released packet
  output logic       m_valid,
  input  logic       m_ready,
  output wr_opcode_t m_opcode,
  output vaddr_t     m_vaddr,
  output len_t       m_len,
  output beats_t     m_beats
);

  credit_t credits;      // Arrived beats not yet claimed
  credit_t credits_nxt;
  logic    accept;

  // Output slot free and beats already in the data queue
  assign s_ready = (!m_valid || m_ready) && (credits >= credit_t'(s_beats));
  assign accept  = s_valid && s_ready;

  always_comb begin
    credits_nxt = credits;
    if (xfer)   credits_nxt = credits_nxt + credit_t'(1);
    if (accept) credits_nxt = credits_nxt - credit_t'(s_beats);  // Claim in same cycle
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      credits <= '0;
      m_valid <= 1'b0;
    end else begin
      credits <= credits_nxt;
      if (accept)       m_valid <= 1'b1;
      else if (m_ready) m_valid <= 1'b0;  // Taken by arbiter
    end
  end

  // Packet fields
  always_ff @(posedge aclk) begin
    if (accept) begin
      m_opcode <= s_opcode;
      m_vaddr  <= s_vaddr;
      m_len    <= s_len;
      m_beats  <= s_beats;
    end
  end

endmodule

// ==== hw/credits/wr_dest_arbiter.sv ====
// ********************
// Round-robin choice among released packets
// Sends the header, then exactly that packet's beats with tlast
// ********************

`timescale 1ns/1ns

`include "rdma_wr_config.svh"

module wr_dest_arbiter import rdma_wr_pkg::*; (
  input  logic                       aclk,
  input  logic                       rst_n,
  // Released packets, one per destination
  input  logic       [`N_DESTS-1:0]  s_valid,
  output logic       [`N_DESTS-1:0]  s_ready,
  input  wr_opcode_t [`N_DESTS-1:0]  s_opcode,
  input  vaddr_t     [`N_DESTS-1:0]  s_vaddr,
  input  len_t       [`N_DESTS-1:0]  s_len,
  input  beats_t     [`N_DESTS-1:0]  s_beats,
  // Data queue heads
  input  logic       [`N_DESTS-1:0]  d_valid,
  output logic       [`N_DESTS-1:0]  d_ready,
  input  data_t      [`N_DESTS-1:0]  d_data,
  // Header out
  output logic                       m_req_valid,
  input  logic                       m_req_ready,
  output dest_t                      m_req_dest,
  output wr_opcode_t                 m_req_opcode,
  output vaddr_t                     m_req_vaddr,
  output len_t                       m_req_len,
  // Data out
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output data_t                      m_axis_tdata,
  output logic                       m_axis_tlast
);

  arb_state_t state;
  dest_t      grant;     // Current or last granted lane
  dest_t      held_idx;  // Lane offered but stalled
  logic       held;
  beats_t     remaining; // Beats still owed to the output
  dest_t      rr_idx;
  logic       rr_found;
  dest_t      sel;
  logic       hdr_xfer;
  logic       beat_xfer;

  // Search starts one after the last grant
  always_comb begin
    int unsigned cand;
    rr_found = 1'b0;
    rr_idx   = grant;
    for (int i = 1; i <= `N_DESTS; i++) begin
      cand = (int'(grant) + i) % `N_DESTS;
      if (!rr_found && s_valid[cand]) begin
        rr_found = 1'b1;
        rr_idx   = dest_t'(cand);
      end
    end
  end

  // A stalled offer stays on the same lane
  assign sel = held ? held_idx : rr_idx;

  // Header channel
  assign m_req_valid  = (state == ARB_IDLE) && (held || rr_found);
  assign m_req_dest   = sel;
  assign m_req_opcode = s_opcode[sel];
  assign m_req_vaddr  = s_vaddr[sel];
  assign m_req_len    = s_len[sel];
  assign hdr_xfer     = m_req_valid && m_req_ready;

  always_comb begin
    for (int i = 0; i < `N_DESTS; i++) begin
      s_ready[i] = hdr_xfer && (sel == dest_t'(i));  // Pop only the chosen gate
    end
  end

  // Data channel, beats are already queued for the granted lane
  assign m_axis_tvalid = (state == ARB_DATA) && d_valid[grant];
  assign m_axis_tdata  = d_data[grant];
  assign m_axis_tlast  = (remaining == beats_t'(1));
  assign beat_xfer     = m_axis_tvalid && m_axis_tready;

  always_comb begin
    for (int i = 0; i < `N_DESTS; i++) begin
      d_ready[i] = (state == ARB_DATA) && (grant == dest_t'(i)) && m_axis_tready;
    end
  end

  // FSM
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state     <= ARB_IDLE;
      grant     <= dest_t'(`N_DESTS - 1);  // First search starts at lane 0
      held      <= 1'b0;
      held_idx  <= '0;
      remaining <= '0;
    end else begin
      case (state)
        ARB_IDLE: begin
          held     <= m_req_valid && !m_req_ready;
          held_idx <= sel;
          if (hdr_xfer) begin
            state     <= ARB_DATA;
            grant     <= sel;
            remaining <= s_beats[sel];
            held      <= 1'b0;
          end
        end
        ARB_DATA: begin
          if (beat_xfer) begin
            remaining <= remaining - beats_t'(1);
            if (m_axis_tlast) state <= ARB_IDLE;  // Packet done, next header may go
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/remote_credits_wr.sv ====
// ********************
// Credit gate for RDMA write requests, top level
// Per-destination request and data queues feed one output stream
// ********************

`timescale 1ns/1ns

`include "rdma_wr_config.svh"

module remote_credits_wr import rdma_wr_pkg::*; (
  input  logic                      aclk,
  input  logic                      rst_n,
  // Write requests
  input  logic                      s_req_valid,
  output logic                      s_req_ready,
  input  dest_t                     s_req_dest,
  input  vaddr_t                    s_req_vaddr,
  input  len_t                      s_req_len,
  // Payload, one stream per destination
  input  logic       [`N_DESTS-1:0] s_axis_tvalid,
  output logic       [`N_DESTS-1:0] s_axis_tready,
  input  data_t      [`N_DESTS-1:0] s_axis_tdata,
  // Packet headers
  output logic                      m_req_valid,
  input  logic                      m_req_ready,
  output dest_t                     m_req_dest,
  output wr_opcode_t                m_req_opcode,
  output vaddr_t                    m_req_vaddr,
  output len_t                      m_req_len,
  // Packet data
  output logic                      m_axis_tvalid,
  input  logic                      m_axis_tready,
  output data_t                     m_axis_tdata,
  output logic                      m_axis_tlast
);

  localparam int RQ_W = `ADDR_W + `LEN_W;

  logic       [`N_DESTS-1:0]           rq_in_valid, rq_in_ready;  // Request queue write side
  logic       [`N_DESTS-1:0]           rq_valid, rq_ready;
  logic       [`N_DESTS-1:0][RQ_W-1:0] rq_data;
  logic       [`N_DESTS-1:0]           p_valid, p_ready;          // Parser to gate
  wr_opcode_t [`N_DESTS-1:0]           p_opcode;
  vaddr_t     [`N_DESTS-1:0]           p_vaddr;
  len_t       [`N_DESTS-1:0]           p_len;
  beats_t     [`N_DESTS-1:0]           p_beats;
  logic       [`N_DESTS-1:0]           g_valid, g_ready;          // Gate to arbiter
  wr_opcode_t [`N_DESTS-1:0]           g_opcode;
  vaddr_t     [`N_DESTS-1:0]           g_vaddr;
  len_t       [`N_DESTS-1:0]           g_len;
  beats_t     [`N_DESTS-1:0]           g_beats;
  logic       [`N_DESTS-1:0]           dq_valid, dq_ready;        // Data queue heads
  data_t      [`N_DESTS-1:0]           dq_data;
  logic       [`N_DESTS-1:0]           xfer;

  // Only the addressed queue sees the request
  assign s_req_ready = rq_in_ready[s_req_dest];

  for (genvar i = 0; i < `N_DESTS; i++) begin : g_lane
    assign rq_in_valid[i] = s_req_valid && (s_req_dest == dest_t'(i));
    assign xfer[i]        = s_axis_tvalid[i] && s_axis_tready[i];  // Beat arrived

    sync_fifo #(.WIDTH(RQ_W), .DEPTH(`QDEPTH)) req_q_inst (
      .aclk(aclk), .rst_n(rst_n),
      .s_valid(rq_in_valid[i]), .s_ready(rq_in_ready[i]),
      .s_data({s_req_vaddr, s_req_len}),
      .m_valid(rq_valid[i]), .m_ready(rq_ready[i]), .m_data(rq_data[i])
    );

    wr_req_parser parser_inst (
      .aclk(aclk), .rst_n(rst_n),
      .s_valid(rq_valid[i]), .s_ready(rq_ready[i]),
      .s_vaddr(rq_data[i][RQ_W-1:`LEN_W]), .s_len(rq_data[i][`LEN_W-1:0]),
      .m_valid(p_valid[i]), .m_ready(p_ready[i]), .m_opcode(p_opcode[i]),
      .m_vaddr(p_vaddr[i]), .m_len(p_len[i]), .m_beats(p_beats[i])
    );

    wr_credit_gate gate_inst (
      .aclk(aclk), .rst_n(rst_n), .xfer(xfer[i]),
      .s_valid(p_valid[i]), .s_ready(p_ready[i]), .s_opcode(p_opcode[i]),
      .s_vaddr(p_vaddr[i]), .s_len(p_len[i]), .s_beats(p_beats[i]),
      .m_valid(g_valid[i]), .m_ready(g_ready[i]), .m_opcode(g_opcode[i]),
      .m_vaddr(g_vaddr[i]), .m_len(g_len[i]), .m_beats(g_beats[i])
    );

    sync_fifo #(.WIDTH(`DATA_W), .DEPTH(`DQ_DEPTH)) data_q_inst (
      .aclk(aclk), .rst_n(rst_n),
      .s_valid(s_axis_tvalid[i]), .s_ready(s_axis_tready[i]), .s_data(s_axis_tdata[i]),
      .m_valid(dq_valid[i]), .m_ready(dq_ready[i]), .m_data(dq_data[i])
    );
  end

  wr_dest_arbiter arb_inst (
    .aclk(aclk), .rst_n(rst_n),
    .s_valid(g_valid), .s_ready(g_ready), .s_opcode(g_opcode),
    .s_vaddr(g_vaddr), .s_len(g_len), .s_beats(g_beats),
    .d_valid(dq_valid), .d_ready(dq_ready), .d_data(dq_data),
    .m_req_valid(m_req_valid), .m_req_ready(m_req_ready), .m_req_dest(m_req_dest),
    .m_req_opcode(m_req_opcode), .m_req_vaddr(m_req_vaddr), .m_req_len(m_req_len),
    .m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready),
    .m_axis_tdata(m_axis_tdata), .m_axis_tlast(m_axis_tlast)
  );

endmodule

// ==== bench/remote_credits_wr_checker.sv ====
// ********************
// Protocol assertions on the top level outputs
// Attached to every remote_credits_wr by bind
// ********************

`timescale 1ns/1ns

`include "rdma_wr_config.svh"

module remote_credits_wr_checker import rdma_wr_pkg::*; (
  input logic       aclk,
  input logic       rst_n,
  input logic       m_req_valid,
  input logic       m_req_ready,
  input dest_t      m_req_dest,
  input wr_opcode_t m_req_opcode,
  input vaddr_t     m_req_vaddr,
  input len_t       m_req_len,
  input logic       m_axis_tvalid,
  input logic       m_axis_tready,
  input data_t      m_axis_tdata,
  input logic       m_axis_tlast
);

  logic rst_seen;      // Reset already sampled on an earlier edge
  int   fail_cnt = 0;  // Assertion failures so far

  always_ff @(posedge aclk) rst_seen <= !rst_n;

  // Stalled header holds valid and fields
  hdr_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    m_req_valid && !m_req_ready |=> m_req_valid &&
      $stable({m_req_dest, m_req_opcode, m_req_vaddr, m_req_len}))
    else begin
      $error("header valid dropped or changed while stalled");
      fail_cnt++;
    end

  beat_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable({m_axis_tdata, m_axis_tlast}))
    else begin
      $error("data beat dropped or changed while stalled");
      fail_cnt++;
    end

  // Header and data phases never overlap
  one_phase: assert property (@(posedge aclk) disable iff (!rst_n)
    !(m_req_valid && m_axis_tvalid))
    else begin
      $error("header and data valid high together");
      fail_cnt++;
    end

  quiet_in_reset: assert property (@(posedge aclk)
    rst_seen && !rst_n |-> !m_req_valid && !m_axis_tvalid)
    else begin
      $error("output valid high during reset");
      fail_cnt++;
    end

endmodule

bind remote_credits_wr remote_credits_wr_checker checker_inst (
  .aclk(aclk), .rst_n(rst_n),
  .m_req_valid(m_req_valid), .m_req_ready(m_req_ready), .m_req_dest(m_req_dest),
  .m_req_opcode(m_req_opcode), .m_req_vaddr(m_req_vaddr), .m_req_len(m_req_len),
  .m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready),
  .m_axis_tdata(m_axis_tdata), .m_axis_tlast(m_axis_tlast)
);

// ==== bench/tb_remote_credits_wr.sv ====
// ********************
// Testbench for the RDMA write credit gate
// Drives requests and payload and checks headers and beats against a packet model
// ********************

`timescale 1ns/1ns

`include "rdma_wr_config.svh"

module tb_remote_credits_wr import rdma_wr_pkg::*; ();

  localparam int HDR_W = 2 + `ADDR_W + `LEN_W;  // {opcode, vaddr, len}

  logic                      aclk, rst_n;
  logic                      s_req_valid, s_req_ready;
  dest_t                     s_req_dest;
  vaddr_t                    s_req_vaddr;
  len_t                      s_req_len;
  logic       [`N_DESTS-1:0] s_axis_tvalid, s_axis_tready;
  data_t      [`N_DESTS-1:0] s_axis_tdata;
  logic                      m_req_valid, m_req_ready;
  dest_t                     m_req_dest;
  wr_opcode_t                m_req_opcode;
  vaddr_t                    m_req_vaddr;
  len_t                      m_req_len;
  logic                      m_axis_tvalid, m_axis_tready, m_axis_tlast;
  data_t                     m_axis_tdata;

  logic [`DEST_W+`ADDR_W+`LEN_W-1:0] req_q [$];  // Requests not yet driven
  data_t              beat_q [`N_DESTS][$];    // Payload not yet driven
  logic [HDR_W-1:0]   exp_hdr [`N_DESTS][$];   // Model headers per lane
  data_t              exp_data [`N_DESTS][$];  // Model words per lane
  data_t              held_word;               // Beat kept back for gating test
  int unsigned        gap_pct, stall_pct;      // Random idle and stall rates
  int                 err_cnt, err_mark, n_pass, n_fail;
  int                 chk_mark;                // Checker failures already counted
  dest_t              cur_dest;                // Lane of the header in flight
  int                 beats_left;

  remote_credits_wr remote_credits_wr_inst (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // Model entry with headers by the MTU split rule and random payload
  task automatic add_request(dest_t d, vaddr_t va, len_t len, bit hold);
    len_t       rem;
    len_t       plen;
    vaddr_t     addr;
    logic [1:0] op;
    data_t      w;
    rem  = len;
    addr = va;
    req_q.push_back({d, va, len});
    for (int i = 0; i < int'(len) / `BEAT_BYTES; i++) begin
      w = {$urandom(), $urandom()};
      exp_data[d].push_back(w);
      if (hold && i == int'(len) / `BEAT_BYTES - 1) held_word = w;  // Sent later
      else beat_q[d].push_back(w);
    end
    while (rem != 0) begin
      plen = (rem <= len_t'(`PMTU_BYTES)) ? rem : len_t'(`PMTU_BYTES);
      if (rem == len) op = (plen == rem) ? OP_ONLY : OP_FIRST;
      else            op = (plen == rem) ? OP_LAST : OP_MIDDLE;
      exp_hdr[d].push_back({op, addr, plen});
      addr = addr + vaddr_t'(`PMTU_BYTES);
      rem  = rem - plen;
    end
  endtask

  task automatic value_error(string name, logic [63:0] got, logic [63:0] exp);
    $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    err_cnt++;
  endtask

  task automatic check_header();
    logic [1:0] eop;
    vaddr_t     eva;
    len_t       elen;
    if (exp_hdr[m_req_dest].size() == 0) begin
      $display("Header from destination %0d that no request asked for", m_req_dest);
      err_cnt++;
    end else begin
      {eop, eva, elen} = exp_hdr[m_req_dest].pop_front();
      assert (m_req_opcode == eop) else value_error("m_req_opcode", m_req_opcode, eop);
      assert (m_req_vaddr == eva) else value_error("m_req_vaddr", m_req_vaddr, eva);
      assert (m_req_len == elen) else value_error("m_req_len", m_req_len, elen);
      cur_dest   = m_req_dest;
      beats_left = int'(elen) / `BEAT_BYTES;  // Beats owed by this header
    end
  endtask

  task automatic check_beat();
    data_t ed;
    if (beats_left == 0 || exp_data[cur_dest].size() == 0) begin
      $display("Data beat at %0t with no header or word left to match it", $time);
      err_cnt++;
    end else begin
      ed = exp_data[cur_dest].pop_front();
      assert (m_axis_tdata == ed) else value_error("m_axis_tdata", m_axis_tdata, ed);
      assert (m_axis_tlast == (beats_left == 1))
        else value_error("m_axis_tlast", m_axis_tlast, beats_left == 1);
      beats_left--;
    end
  endtask

  function automatic bit drained();
    bit empty;
    empty = (req_q.size() == 0) && !s_req_valid && (s_axis_tvalid == '0) && (beats_left == 0);
    for (int d = 0; d < `N_DESTS; d++) begin
      empty &= (beat_q[d].size() == 0) && (exp_hdr[d].size() == 0);
      empty &= (exp_data[d].size() == 0);
    end
    return empty;
  endfunction

  task automatic wait_drained(int limit);
    int cyc;
    cyc = 0;
    while (!drained() && cyc < limit) begin
      @(posedge aclk);
      cyc++;
    end
    if (!drained()) begin
      $display("Timeout: packets or beats still undelivered after %0d cycles", limit);
      err_cnt++;
    end
  endtask

  task automatic finish_test(string name);
    int chk_now;
    chk_now  = remote_credits_wr_inst.checker_inst.fail_cnt;
    err_cnt  = err_cnt + chk_now - chk_mark;
    chk_mark = chk_now;
    if (err_cnt == err_mark) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: FAILED with %0d errors", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // Input driver samples handshakes at negedge and changes 2 ns after posedge
  initial begin
    logic                req_took;
    logic [`N_DESTS-1:0] beat_took;
    s_req_valid   = 1'b0;
    s_req_dest    = '0;
    s_req_vaddr   = '0;
    s_req_len     = '0;
    s_axis_tvalid = '0;
    s_axis_tdata  = '0;
    m_req_ready   = 1'b0;
    m_axis_tready = 1'b0;
    forever begin
      @(negedge aclk);
      req_took  = s_req_valid && s_req_ready;
      beat_took = s_axis_tvalid & s_axis_tready;
      @(posedge aclk);
      #2;
      if (req_took) s_req_valid = 1'b0;
      if (!s_req_valid && req_q.size() > 0 && $urandom_range(99) >= gap_pct) begin
        {s_req_dest, s_req_vaddr, s_req_len} = req_q.pop_front();
        s_req_valid = 1'b1;
      end
      for (int d = 0; d < `N_DESTS; d++) begin
        if (beat_took[d]) s_axis_tvalid[d] = 1'b0;
        if (!s_axis_tvalid[d] && beat_q[d].size() > 0 && $urandom_range(99) >= gap_pct) begin
          s_axis_tdata[d]  = beat_q[d].pop_front();
          s_axis_tvalid[d] = 1'b1;
        end
      end
      m_req_ready   = ($urandom_range(99) >= stall_pct);  // Output back-pressure
      m_axis_tready = ($urandom_range(99) >= stall_pct);
    end
  end

  // Output monitor sees transfers half a cycle before their edge
  initial begin
    beats_left = 0;
    cur_dest   = '0;
    forever begin
      @(negedge aclk);
      if (rst_n && m_req_valid && m_req_ready) check_header();
      if (rst_n && m_axis_tvalid && m_axis_tready) check_beat();
    end
  end

  initial begin
    void'($urandom(80236));
    err_cnt   = 0;
    err_mark  = 0;
    chk_mark  = 0;
    n_pass    = 0;
    n_fail    = 0;
    gap_pct   = 0;
    stall_pct = 0;
    rst_n     = 1'b0;
    repeat (16) @(posedge aclk);
    #2 rst_n = 1'b1;

    add_request(1'b0, 32'h1000_0040, 16'd24, 1'b0);  // One ONLY packet
    wait_drained(500);
    finish_test("single ONLY packet");

    add_request(1'b1, 32'h2000_0100, 16'd72, 1'b0);  // 4 + 4 + 1 beats
    wait_drained(500);
    finish_test("FIRST MIDDLE LAST split");

    add_request(1'b0, 32'h3000_0000, 16'd32, 1'b1);  // Fourth beat withheld
    for (int i = 0; i < 60; i++) begin
      @(negedge aclk);
      assert (!m_req_valid) else begin
        $display("Header released at %0t before all of its beats arrived", $time);
        err_cnt++;
      end
    end
    beat_q[0].push_back(held_word);
    wait_drained(500);
    finish_test("credit gating");

    for (int i = 0; i < 3; i++) begin
      add_request(1'b0, vaddr_t'(32'h4000_0000 + 32'h100 * i), 16'd40, 1'b0);
      add_request(1'b1, vaddr_t'(32'h5000_0000 + 32'h100 * i), 16'd56, 1'b0);
    end
    wait_drained(2000);
    finish_test("two destinations interleaved");

    gap_pct   = 30;
    stall_pct = 30;
    for (int i = 0; i < 20; i++) begin
      add_request(dest_t'($urandom_range(`N_DESTS - 1)), vaddr_t'($urandom()),
                  len_t'(`BEAT_BYTES * $urandom_range(12, 1)), 1'b0);
    end
    wait_drained(10000);
    finish_test("random stalls and gaps");

    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, err_cnt);
    if (n_fail == 0 && err_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+common
common/rdma_wr_pkg.sv
hw/sync_fifo.sv
hw/credits/wr_req_parser.sv
hw/credits/wr_credit_gate.sv
hw/credits/wr_dest_arbiter.sv
hw/remote_credits_wr.sv
bench/remote_credits_wr_checker.sv
bench/tb_remote_credits_wr.sv

// ==== Makefile ====
# Verilator build and run of the RDMA write credit gate testbench

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module tb_remote_credits_wr -Mdir obj_dir
	./obj_dir/Vtb_remote_credits_wr | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
